//--- tb.f
verilog/icache_pkg.sv
verilog/icache_way_if.sv
verilog/icache_way.sv
verilog/icache_ctrl.sv
verilog/icache_resp.sv
verilog/icache_top.sv
bench/icache_mem_model.sv
bench/icache_props.sv
bench/icache_tb.sv

//--- bench/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;
    import icache_pkg::*;

    localparam int ways      = 2;
    localparam int set_bits  = 4;
    localparam int word_bits = 2;
    localparam int sets      = 1 << set_bits;
    localparam int words     = 1 << word_bits;
    localparam int off_w     = word_bits + 2;
    localparam int tag_w     = addr_w - set_bits - off_w;

    localparam logic [31:0] lfsr_seed = 32'ha2ff;
    localparam logic [31:0] mem_mix   = 32'h9e37_79b1;
    localparam int n_directed   = 14;
    localparam int n_random     = 40;
    localparam int worst_cycles = words * 8 + 10;  // single mode, longest delays
    localparam int timeout_ns   = ((n_directed + n_random) * worst_cycles + 100) * 10;

    logic  clock, reset, valid, rburst, ready, rstart, rok;
    addr_t addr, raddr;
    word_t data, rdata;
    len_t  rlen;

    // shadow cache
    logic [tag_w-1:0] sh_tag   [sets][ways];
    logic             sh_valid [sets][ways];
    int               sh_ptr   [sets];

    addr_t       cur_addr, want_raddr;     // access in flight
    logic        cur_hit, cur_burst, busy;
    len_t        want_len;
    int          cyc, starts, want_starts, done_count, issued;
    int          errors, tests_run, tests_failed, test_errors;
    logic [31:0] lfsr;

    icache_top #(
        .ways      (ways),
        .set_bits  (set_bits),
        .word_bits (word_bits)
    ) uut (
        .clock  (clock),
        .reset  (reset),
        .addr   (addr),
        .valid  (valid),
        .rburst (rburst),
        .data   (data),
        .ready  (ready),
        .rstart (rstart),
        .raddr  (raddr),
        .rlen   (rlen),
        .rok    (rok),
        .rdata  (rdata)
    );

    icache_mem_model #(
        .mix  (mem_mix),
        .seed (lfsr_seed)
    ) mem (
        .clock  (clock),
        .reset  (reset),
        .rstart (rstart),
        .raddr  (raddr),
        .rlen   (rlen),
        .rok    (rok),
        .rdata  (rdata)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog: accesses did not complete in time");
        $display(">>> FAIL");
        $finish;
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    function automatic word_t mem_word(input addr_t a);
        return (a ^ ~mem_mix) * mem_mix;
    endfunction

    function automatic logic shadow_hit(input addr_t a);
        logic             hit;
        int               idx;
        logic [tag_w-1:0] tag;
        hit = 1'b0;
        idx = a[off_w +: set_bits];
        tag = a[addr_w-1 -: tag_w];
        for (int w = 0; w < ways; w++) begin
            if (sh_valid[idx][w] && sh_tag[idx][w] == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // fill the round robin victim, then move the pointer on
    function automatic void shadow_fill(input addr_t a);
        int idx;
        idx = a[off_w +: set_bits];
        sh_tag[idx][sh_ptr[idx]]   = a[addr_w-1 -: tag_w];
        sh_valid[idx][sh_ptr[idx]] = 1'b1;
        sh_ptr[idx] = (sh_ptr[idx] + 1) % ways;
    endfunction

    task automatic fetch(input addr_t a, input logic burst);
        cur_addr  = a;
        cur_burst = burst;
        cur_hit   = shadow_hit(a);
        if (!cur_hit) begin
            shadow_fill(a);
        end
        issued++;
        @(negedge clock);
        addr   = a;
        valid  = 1'b1;
        rburst = burst;
        @(negedge clock);
        valid = 1'b0;     // addr and rburst held until ready
        wait (done_count == issued);
        @(negedge clock);
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // ----------------------------------------
    // checker
    // ----------------------------------------

    always @(posedge clock) begin
        if (reset) begin
            busy = 1'b0;
        end else begin
            if (busy) cyc++;
            if (valid) begin
                busy   = 1'b1;
                cyc    = 0;
                starts = 0;
            end
            if (rstart) begin
                want_raddr = {cur_addr[addr_w-1:off_w], off_w'(0)};
                if (!cur_burst) begin
                    want_raddr = want_raddr + 4 * starts;   // one word per single beat
                end
                want_len = cur_burst ? len_t'(words - 1) : '0;
                if (!busy) begin
                    $display("rstart raised at %0t with no access pending", $time);
                    errors++;
                end else if (raddr !== want_raddr) begin
                    $display("Fail %0t raddr: expected %h, got %h",
                             $time, want_raddr, raddr);
                    errors++;
                end
                if (rlen !== want_len) begin
                    $display("Fail %0t rlen: expected %0d, got %0d",
                             $time, want_len, rlen);
                    errors++;
                end
                starts++;
            end
            if (ready) begin
                want_starts = cur_hit ? 0 : (cur_burst ? 1 : words);
                if (!busy) begin
                    $display("ready raised at %0t with no access pending", $time);
                    errors++;
                end
                if (data !== mem_word(cur_addr)) begin
                    $display("Fail %0t data: expected %h, got %h",
                             $time, mem_word(cur_addr), data);
                    errors++;
                end
                if (starts != want_starts) begin
                    $display("Fail %0t rstart count: expected %0d, got %0d",
                             $time, want_starts, starts);
                    errors++;
                end
                // a hit shows ready at the first edge after the valid edge
                if (cur_hit && cyc != 1) begin
                    $display("Fail %0t ready latency: expected 1, got %0d", $time, cyc);
                    errors++;
                end
                busy = 1'b0;
                done_count++;
            end
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    initial begin
        addr_t victim;
        addr_t ra;
        logic  rb;
        addr   = '0;
        valid  = 1'b0;
        rburst = 1'b0;
        reset  = 1'b1;
        lfsr   = lfsr_seed;
        done_count   = 0;
        issued       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errors  = 0;
        for (int s = 0; s < sets; s++) begin
            sh_ptr[s] = 0;
            for (int w = 0; w < ways; w++) begin
                sh_valid[s][w] = 1'b0;
                sh_tag[s][w]   = '0;
            end
        end
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        if (ready !== 1'b0) begin
            $display("Fail %0t ready: expected 0, got %b", $time, ready);
            errors++;
        end
        if (rstart !== 1'b0) begin
            $display("Fail %0t rstart: expected 0, got %b", $time, rstart);
            errors++;
        end
        fetch(32'h0000_1004, 1'b1);
        report_test("1 burst miss after reset");

        for (int w = 0; w < words; w++) begin
            fetch(32'h0000_1000 + 4 * w, 1'b0);
        end
        report_test("2 hits on a filled block");

        fetch(32'h0000_2020, 1'b0);     // single mode refill
        fetch(32'h0000_202c, 1'b0);
        fetch(32'h0000_2024, 1'b1);
        report_test("3 single mode miss");

        // three tags on set 3
        fetch(32'h0000_1030, 1'b1);
        fetch(32'h0000_2034, 1'b0);
        fetch(32'h0000_1038, 1'b1);
        fetch(32'h0000_203c, 1'b0);
        victim = {sh_tag[3][sh_ptr[3]], set_bits'(3), off_w'(0)};
        fetch(32'h0000_3030, 1'b1);
        fetch(victim, 1'b1);            // evicted block must miss again
        report_test("4 round robin eviction");

        for (int i = 0; i < n_random; i++) begin
            ra = 32'h0000_4000 | (rand_bits(8) << 2);
            rb = 1'(rand_bits(1));
            fetch(ra, rb);
        end
        report_test("5 random accesses");

        $display("%0d tests, %0d failed, %0d accesses, %0d errors",
                 tests_run, tests_failed, issued, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- bench/icache_props.sv
`timescale 1ns/1ps

module icache_props (
    input logic             clock,
    input logic             reset,
    input logic             valid,
    input logic             rburst,
    input logic             ready,
    input logic             rstart,
    input icache_pkg::len_t rlen
);

    logic burst_at_miss;    // rburst seen with the last valid

    always_ff @(posedge clock) begin
        if (reset) begin
            burst_at_miss <= 1'b1;
        end else if (valid) begin
            burst_at_miss <= rburst;
        end
    end

    a_start_not_ready: assert property (@(posedge clock) disable iff (reset)
        !(rstart && ready))
        else $error("rstart and ready high in the same cycle");

    a_ready_pulse: assert property (@(posedge clock) disable iff (reset)
        ready |=> !ready)
        else $error("ready high for two cycles in a row");

    // single mode asks for one word at a time
    a_single_len: assert property (@(posedge clock) disable iff (reset)
        (rstart && !burst_at_miss) |-> (rlen == '0))
        else $error("rlen not zero on a single mode rstart");

endmodule

bind icache_top icache_props u_props (
    .clock  (clock),
    .reset  (reset),
    .valid  (valid),
    .rburst (rburst),
    .ready  (ready),
    .rstart (rstart),
    .rlen   (rlen)
);

//--- bench/icache_mem_model.sv
`timescale 1ns/1ps

module icache_mem_model #(
    parameter logic [31:0] mix  = 32'h9e37_79b1,    // odd, so every address gives its own word
    parameter logic [31:0] seed = 32'h0000_0001
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              rstart,
    input  icache_pkg::addr_t raddr,
    input  icache_pkg::len_t  rlen,
    output logic              rok,
    output icache_pkg::word_t rdata
);
    import icache_pkg::*;

    logic [31:0] lfsr;
    addr_t       beat_addr;
    int          beats;
    int          delay;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // memory contents, a fixed function of the byte address
    function automatic word_t word_at(input addr_t a);
        return (a ^ ~mix) * mix;
    endfunction

    initial begin
        rok   = 1'b0;
        rdata = '0;
        lfsr  = seed;
    end

    // ----------------------------------------
    // responder
    // ----------------------------------------

    always begin
        @(posedge clock);
        if (!reset && rstart) begin
            beat_addr = raddr;
            beats     = int'(rlen) + 1;
            for (int b = 0; b < beats; b++) begin
                delay = 0;
                for (int i = 0; i < 2; i++) begin      // 0 to 3 idle cycles
                    delay = (delay << 1) | lfsr[0];
                    lfsr  = lfsr_step(lfsr);
                end
                repeat (delay) @(posedge clock);
                @(negedge clock);
                rok   <= 1'b1;
                rdata <= word_at(beat_addr);
                @(negedge clock);
                rok       <= 1'b0;  // one cycle pulse
                beat_addr = beat_addr + 4;
            end
        end
    end

endmodule

//--- verilog/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
    parameter int ways      = 2,    // power of two
    parameter int set_bits  = 4,
    parameter int word_bits = 2     // 16 byte blocks
) (
    input  logic              clock,
    input  logic              reset,

    // core side
    input  icache_pkg::addr_t addr,
    input  logic              valid,
    input  logic              rburst,
    output icache_pkg::word_t data,
    output logic              ready,

    // memory side
    output logic              rstart,
    output icache_pkg::addr_t raddr,
    output icache_pkg::len_t  rlen,
    input  logic              rok,
    input  icache_pkg::word_t rdata
);

    logic            lookup_hit;
    logic [ways-1:0] hit_way;
    logic            deliver;

    // one bus per way
    icache_way_if #(
        .set_bits  (set_bits),
        .word_bits (word_bits)
    ) way_bus [ways] ();

    // ----------------------------------------
    // controller
    // ----------------------------------------

    icache_ctrl #(
        .ways      (ways),
        .set_bits  (set_bits),
        .word_bits (word_bits)
    ) u_ctrl (
        .clock      (clock),
        .reset      (reset),
        .addr       (addr),
        .valid      (valid),
        .rburst     (rburst),
        .rok        (rok),
        .rdata      (rdata),
        .rstart     (rstart),
        .raddr      (raddr),
        .rlen       (rlen),
        .lookup_hit (lookup_hit),
        .hit_way    (hit_way),
        .deliver    (deliver),
        .way_bus    (way_bus)
    );

    // ----------------------------------------
    // ways and response
    // ----------------------------------------

    for (genvar g = 0; g < ways; g++) begin : g_way
        icache_way #(
            .set_bits  (set_bits),
            .word_bits (word_bits)
        ) u_way (
            .clock (clock),
            .reset (reset),
            .bus   (way_bus[g])
        );
    end

    icache_resp #(
        .ways      (ways),
        .word_bits (word_bits)
    ) u_resp (
        .clock      (clock),
        .reset      (reset),
        .addr       (addr),
        .way_bus    (way_bus),
        .deliver    (deliver),
        .lookup_hit (lookup_hit),
        .hit_way    (hit_way),
        .data       (data),
        .ready      (ready)
    );

endmodule

//--- verilog/icache_resp.sv
`timescale 1ns/1ps

module icache_resp #(
    parameter int ways      = 2,
    parameter int word_bits = 2
) (
    input  logic              clock,
    input  logic              reset,
    input  icache_pkg::addr_t addr,
    icache_way_if.resp        way_bus [ways],
    input  logic              deliver,
    output logic              lookup_hit,
    output logic [ways-1:0]   hit_way,
    output icache_pkg::word_t data,
    output logic              ready
);
    import icache_pkg::*;

    localparam int words   = 1 << word_bits;
    localparam int block_w = word_w << word_bits;

    logic [block_w-1:0] blocks [ways];
    logic [block_w-1:0] sel_block;
    logic [word_bits:0] word_off;       // word index within the block
    word_t              sel_word;

    for (genvar g = 0; g < ways; g++) begin : g_gather
        assign hit_way[g] = way_bus[g].hit;
        assign blocks[g]  = way_bus[g].block;
    end

    assign lookup_hit = |hit_way;

    // and-or mux, at most one way hits
    always_comb begin
        sel_block = '0;
        for (int w = 0; w < ways; w++) begin
            if (hit_way[w]) begin
                sel_block |= blocks[w];
            end
        end
    end

    assign word_off = (word_bits + 1)'((addr >> 2) & (words - 1));
    assign sel_word = sel_block[word_off*word_w +: word_w];

    // ----------------------------------------
    // output stage
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            ready <= 1'b0;
        end else begin
            ready <= deliver;   // one cycle per deliver
        end
    end

    always_ff @(posedge clock) begin
        if (deliver) begin
            data <= sel_word;
        end
    end

endmodule

//--- verilog/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int ways      = 2,
    parameter int set_bits  = 4,
    parameter int word_bits = 2
) (
    input  logic              clock,
    input  logic              reset,
    input  icache_pkg::addr_t addr,
    input  logic              valid,
    input  logic              rburst,
    input  logic              rok,
    input  icache_pkg::word_t rdata,
    output logic              rstart,
    output icache_pkg::addr_t raddr,
    output icache_pkg::len_t  rlen,
    input  logic              lookup_hit,
    input  logic [ways-1:0]   hit_way,
    output logic              deliver,
    icache_way_if.ctrl        way_bus [ways]
);
    import icache_pkg::*;

    localparam int words    = 1 << word_bits;
    localparam int sets     = 1 << set_bits;
    localparam int off_w    = word_bits + 2;        // byte offset within a block
    localparam int tag_w    = addr_w - set_bits - off_w;
    localparam int way_bits = (ways > 1) ? $clog2(ways) : 1;

    typedef enum logic [1:0] {
        st_idle,
        st_refill,
        st_replay
    } state_t;

    state_t              state;
    addr_t               miss_addr;     // block aligned
    logic                burst_r;       // rburst at the miss edge
    logic [word_bits:0]  count;         // rok pulses so far
    logic [way_bits-1:0] fill_way;      // victim of the current refill
    logic [way_bits-1:0] rr_ptr [sets];

    addr_t               look_addr;
    logic [set_bits-1:0] look_index;
    logic [tag_w-1:0]    look_tag;
    logic [set_bits-1:0] addr_index;
    logic                miss_start;
    logic                refill_beat;
    logic                last_beat;

    // ----------------------------------------
    // lookup address
    // ----------------------------------------

    // core address while idle, the latched block during refill and replay
    assign look_addr  = (state == st_idle) ? addr : miss_addr;
    assign look_index = look_addr[off_w +: set_bits];
    assign look_tag   = look_addr[addr_w-1 -: tag_w];
    assign addr_index = addr[off_w +: set_bits];

    assign miss_start  = (state == st_idle) && valid && !lookup_hit;
    assign refill_beat = (state == st_refill) && rok;
    assign last_beat   = refill_beat && (count == (word_bits + 1)'(words - 1));

    assign rlen = burst_r ? len_t'(words - 1) : '0;

    // hit straight from idle, or the refilled way once replayed
    assign deliver = ((state == st_idle) && valid && lookup_hit) ||
                     ((state == st_replay) && hit_way[fill_way]);

    // ----------------------------------------
    // way buses
    // ----------------------------------------

    for (genvar g = 0; g < ways; g++) begin : g_bus
        assign way_bus[g].index     = look_index;
        assign way_bus[g].tag       = look_tag;
        assign way_bus[g].fill_word = rdata;
        assign way_bus[g].fill_we   = refill_beat && (fill_way == way_bits'(g));
        assign way_bus[g].fill_done = last_beat && (fill_way == way_bits'(g));
    end

    // ----------------------------------------
    // state machine
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= st_idle;
            rstart  <= 1'b0;
            burst_r <= 1'b0;
            count   <= '0;
        end else begin
            rstart <= 1'b0;     // single cycle strobe
            case (state)
                st_idle: begin
                    if (miss_start) begin
                        state   <= st_refill;
                        rstart  <= 1'b1;
                        burst_r <= rburst;
                        count   <= '0;
                    end
                end
                st_refill: begin
                    if (rok) begin
                        count <= count + 1'b1;
                        if (last_beat) begin
                            state <= st_replay;
                        end else if (!burst_r) begin
                            rstart <= 1'b1;     // next single beat
                        end
                    end
                end
                st_replay: state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    // miss address and memory address
    always_ff @(posedge clock) begin
        if (miss_start) begin
            miss_addr <= {addr[addr_w-1:off_w], off_w'(0)};
            raddr     <= {addr[addr_w-1:off_w], off_w'(0)};
        end else if (refill_beat && !burst_r) begin
            raddr <= raddr + 4;
        end
    end

    // ----------------------------------------
    // replacement
    // ----------------------------------------

    // victim taken at the miss so the pointer may move before replay
    always_ff @(posedge clock) begin
        if (reset) begin
            fill_way <= '0;
        end else if (miss_start) begin
            fill_way <= rr_ptr[addr_index];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rr_ptr <= '{default: '0};
        end else if (last_beat) begin
            if (fill_way == way_bits'(ways - 1)) begin
                rr_ptr[look_index] <= '0;       // wrap
            end else begin
                rr_ptr[look_index] <= fill_way + 1'b1;
            end
        end
    end

endmodule

//--- verilog/icache_way.sv
`timescale 1ns/1ps

module icache_way #(
    parameter int set_bits  = 4,
    parameter int word_bits = 2
) (
    input logic       clock,
    input logic       reset,
    icache_way_if.way bus
);
    import icache_pkg::*;

    localparam int sets    = 1 << set_bits;
    localparam int tag_w   = addr_w - set_bits - word_bits - 2;
    localparam int block_w = word_w << word_bits;

    // ----------------------------------------
    // storage
    // ----------------------------------------

    logic [tag_w-1:0]   tag_mem   [sets];
    logic [block_w-1:0] block_mem [sets];
    logic [sets-1:0]    valid_r;        // one bit per set

    // ----------------------------------------
    // lookup
    // ----------------------------------------

    // a set with a stale tag but no valid bit never hits
    assign bus.hit   = valid_r[bus.index] && (tag_mem[bus.index] == bus.tag);
    assign bus.block = block_mem[bus.index];

    // ----------------------------------------
    // refill
    // ----------------------------------------

    // valid bits
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_r <= '0;
        end else if (bus.fill_done) begin
            valid_r[bus.index] <= 1'b1;
        end
    end

    // tag written once the last word is in
    always_ff @(posedge clock) begin
        if (bus.fill_done) begin
            tag_mem[bus.index] <= bus.tag;
        end
    end

    // new word enters at the top, so the first beat ends up as word 0
    generate
        if (word_bits > 0) begin : g_shift
            always_ff @(posedge clock) begin
                if (bus.fill_we) begin
                    block_mem[bus.index] <= {bus.fill_word,
                                             block_mem[bus.index][block_w-1:word_w]};
                end
            end
        end else begin : g_single
            // one word per block, nothing to shift
            always_ff @(posedge clock) begin
                if (bus.fill_we) begin
                    block_mem[bus.index] <= bus.fill_word;
                end
            end
        end
    endgenerate

endmodule

//--- verilog/icache_way_if.sv
`timescale 1ns/1ps

interface icache_way_if #(
    parameter int set_bits  = 4,
    parameter int word_bits = 2
);
    import icache_pkg::*;

    localparam int tag_w   = addr_w - set_bits - word_bits - 2;
    localparam int block_w = word_w << word_bits;

    // lookup side
    logic [set_bits-1:0] index;
    logic [tag_w-1:0]    tag;
    logic                hit;       // tag match and valid
    logic [block_w-1:0]  block;     // stored block at index

    // refill side
    logic                fill_we;   // one pulse per refill word
    word_t               fill_word;
    logic                fill_done; // tag write and valid set

    modport ctrl (output index, tag, fill_we, fill_word, fill_done);

    modport way (
        input  index, tag, fill_we, fill_word, fill_done,
        output hit, block
    );

    modport resp (input hit, block);

endinterface

//--- verilog/icache_pkg.sv
package icache_pkg;

    // ----------------------------------------
    // bus widths
    // ----------------------------------------

    localparam int addr_w = 32;     // byte address on core and memory side
    localparam int word_w = 32;     // one instruction word
    localparam int len_w  = 8;      // rlen field of the memory port

    // ----------------------------------------
    // bus types
    // ----------------------------------------

    // byte address, low two bits are the byte lane
    typedef logic [addr_w-1:0] addr_t;

    // fetched word, also the refill beat
    typedef logic [word_w-1:0] word_t;

    typedef logic [len_w-1:0] len_t;    // beats minus one

endpackage
